// ==== source/cache_pkg.sv ====
package cache_pkg;

    // a line address splits into tag (upper bits) and set index (lower bits)
    localparam int LINE_ADDR_W = 5;
    localparam int INDEX_W     = 3;
    localparam int TAG_W       = LINE_ADDR_W - INDEX_W;
    localparam int BLOCK_W     = 64;

    localparam int NUM_SETS    = 2 ** INDEX_W;     // L1 is direct mapped, one line per set
    localparam int NUM_LINES   = 2 ** LINE_ADDR_W; // lines held by the backing memory

    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    typedef logic [BLOCK_W-1:0] line_t;

    // level of the hierarchy that supplied a response
    typedef enum logic [1:0]
    {
        SRC_L1     = 2'd0,
        SRC_VICTIM = 2'd1,
        SRC_MEMORY = 2'd2
    } source_e;

    // valid is a single cycle pulse, data and source are only meaningful with it
    typedef struct packed
    {
        logic    valid;
        line_t   data;
        source_e source;
    } fetch_resp_t;

endpackage

// ==== source/mem_pkg.sv ====
package mem_pkg;

    // one displaced line held by the victim buffer
    typedef struct packed
    {
        cache_pkg::line_addr_t addr;
        cache_pkg::line_t      data;
    } victim_entry_t;

    typedef enum logic
    {
        LAT_LOW  = 1'b0,   // result one cycle after the lookup
        LAT_HIGH = 1'b1    // result two cycles after the lookup
    } victim_latency_e;

    typedef enum logic [1:0]
    {
        ST_IDLE        = 2'd0,
        ST_VICTIM_WAIT = 2'd1,
        ST_MEM_WAIT    = 2'd2,
        ST_FILL        = 2'd3
    } ctrl_state_e;

endpackage

// ==== source/victim_buffer.sv ====
`timescale 1ns/1ps

module victim_buffer #(
    parameter int                       VICTIM_DEPTH   = 4,
    parameter mem_pkg::victim_latency_e VICTIM_LATENCY = mem_pkg::LAT_HIGH
) (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   victim_lookup,
    input  cache_pkg::line_addr_t  lookup_addr,
    input  logic                   victim_write,
    input  mem_pkg::victim_entry_t victim_wentry,
    output logic                   victim_done,
    output logic                   victim_hit,
    output cache_pkg::line_t       victim_data
);
    import cache_pkg::*;
    import mem_pkg::*;

    localparam int CNT_W = $clog2(VICTIM_DEPTH + 1);
    localparam int IDX_W = (VICTIM_DEPTH > 1) ? $clog2(VICTIM_DEPTH) : 1;

    victim_entry_t           entries [VICTIM_DEPTH];   // slot 0 holds the oldest entry
    logic [VICTIM_DEPTH-1:0] valid;
    logic [CNT_W-1:0]        count;
    logic                    full;
    logic [VICTIM_DEPTH-1:0] match;
    logic                    match_any;
    logic [IDX_W-1:0]        match_idx;
    line_t                   match_data;
    logic                    done_s1;
    logic                    hit_s1;
    line_t                   data_s1;

    assign full = (count == CNT_W'(VICTIM_DEPTH));

    // the loop runs downward so the lowest matching slot wins
    always_comb
    begin
        match_any  = 1'b0;
        match_idx  = '0;
        match_data = '0;
        for (int i = VICTIM_DEPTH - 1; i >= 0; i--)
        begin
            match[i] = valid[i] && (entries[i].addr == lookup_addr);
            if (match[i])
            begin
                match_any  = 1'b1;
                match_idx  = IDX_W'(i);
                match_data = entries[i].data;
            end
        end
    end

    // valid bits stay packed from slot 0 upward, so a removal is a plain shift
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            valid <= '0;
            count <= '0;
        end
        else if (victim_write)
        begin
            if (!full)
            begin
                valid <= (valid << 1) | VICTIM_DEPTH'(1);
                count <= count + 1'b1;
            end
        end
        else if (victim_lookup && match_any)
        begin
            valid <= valid >> 1;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (victim_write)
        begin
            if (full)
            begin
                for (int i = 0; i < VICTIM_DEPTH - 1; i++)
                begin
                    entries[i] <= entries[i + 1];   // oldest falls out of slot 0
                end
                entries[VICTIM_DEPTH - 1] <= victim_wentry;
            end
            else
            begin
                entries[count[IDX_W-1:0]] <= victim_wentry;
            end
        end
        else if (victim_lookup && match_any)
        begin
            for (int i = 0; i < VICTIM_DEPTH - 1; i++)
            begin
                if (i >= int'(match_idx))
                begin
                    entries[i] <= entries[i + 1];   // younger entries close the gap
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            done_s1 <= 1'b0;
            hit_s1  <= 1'b0;
        end
        else
        begin
            done_s1 <= victim_lookup;
            hit_s1  <= victim_lookup && match_any;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (victim_lookup)
        begin
            data_s1 <= match_data;
        end
    end

    generate
        if (VICTIM_LATENCY == LAT_LOW)
        begin : g_lat_low
            assign victim_done = done_s1;
            assign victim_hit  = hit_s1;
            assign victim_data = data_s1;
        end
        else
        begin : g_lat_high
            logic  done_s2;
            logic  hit_s2;
            line_t data_s2;

            always_ff @(posedge CLK)
            begin
                if (!rst_n)
                begin
                    done_s2 <= 1'b0;
                    hit_s2  <= 1'b0;
                end
                else
                begin
                    done_s2 <= done_s1;
                    hit_s2  <= hit_s1;
                end
            end

            always_ff @(posedge CLK)
            begin
                data_s2 <= data_s1;
            end

            assign victim_done = done_s2;
            assign victim_hit  = hit_s2;
            assign victim_data = data_s2;
        end
    endgenerate

    a_no_lookup_with_write: assert property (@(posedge CLK) disable iff (!rst_n)
        !(victim_lookup && victim_write))
        else $error("victim lookup and write in the same cycle");

endmodule

// ==== source/line_memory.sv ====
`timescale 1ns/1ps

module line_memory #(
    parameter int MEM_LATENCY = 3
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  mem_rd,
    input  cache_pkg::line_addr_t mem_addr,
    output logic                  mem_done,
    output cache_pkg::line_t      mem_data
);
    import cache_pkg::*;

    line_t                  mem [NUM_LINES];
    logic [MEM_LATENCY-1:0] rd_pipe;
    line_t                  data_pipe [MEM_LATENCY];

    // image path is relative to the simulation run directory
    initial
    begin
        $readmemh("tests/line_image.hex", mem);
    end

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            rd_pipe <= '0;
        end
        else
        begin
            rd_pipe <= (rd_pipe << 1) | MEM_LATENCY'(mem_rd);
        end
    end

    // data moves in step with the strobe so reads may overlap
    always_ff @(posedge CLK)
    begin
        data_pipe[0] <= mem[mem_addr];
        for (int i = 1; i < MEM_LATENCY; i++)
        begin
            data_pipe[i] <= data_pipe[i - 1];
        end
    end

    assign mem_done = rd_pipe[MEM_LATENCY-1];
    assign mem_data = data_pipe[MEM_LATENCY-1];

endmodule

// ==== source/fetch_cache_ctrl.sv ====
`timescale 1ns/1ps

module fetch_cache_ctrl (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   req,
    input  cache_pkg::line_addr_t  req_addr,
    output logic                   busy,
    output cache_pkg::fetch_resp_t resp,
    output logic                   victim_lookup,
    output cache_pkg::line_addr_t  lookup_addr,
    input  logic                   victim_done,
    input  logic                   victim_hit,
    input  cache_pkg::line_t       victim_data,
    output logic                   victim_write,
    output mem_pkg::victim_entry_t victim_wentry,
    output logic                   mem_rd,
    output cache_pkg::line_addr_t  mem_addr,
    input  logic                   mem_done,
    input  cache_pkg::line_t       mem_data
);
    import cache_pkg::*;
    import mem_pkg::*;

    logic [TAG_W-1:0]    tag_q [NUM_SETS];
    line_t               data_q [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    ctrl_state_e         state;
    line_addr_t          addr_q;
    logic                lookup_q;
    logic                mem_rd_q;
    logic                resp_valid_q;
    line_t               resp_data_q;
    source_e             resp_src_q;

    logic [INDEX_W-1:0]  req_idx;
    logic [TAG_W-1:0]    req_tag;
    logic [INDEX_W-1:0]  fill_idx;
    logic [TAG_W-1:0]    fill_tag;
    logic                l1_hit;

    assign req_idx  = req_addr[INDEX_W-1:0];
    assign req_tag  = req_addr[LINE_ADDR_W-1:INDEX_W];
    assign fill_idx = addr_q[INDEX_W-1:0];
    assign fill_tag = addr_q[LINE_ADDR_W-1:INDEX_W];
    assign l1_hit   = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            state        <= ST_IDLE;
            lookup_q     <= 1'b0;
            mem_rd_q     <= 1'b0;
            resp_valid_q <= 1'b0;
            valid_q      <= '0;
        end
        else
        begin
            lookup_q     <= 1'b0;
            mem_rd_q     <= 1'b0;
            resp_valid_q <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (req)
                    begin
                        if (l1_hit)
                        begin
                            resp_valid_q <= 1'b1;   // hit answers in the next cycle
                        end
                        else
                        begin
                            lookup_q <= 1'b1;
                            state    <= ST_VICTIM_WAIT;
                        end
                    end
                end
                ST_VICTIM_WAIT:
                begin
                    if (victim_done)
                    begin
                        if (victim_hit)
                        begin
                            resp_valid_q <= 1'b1;
                            state        <= ST_FILL;
                        end
                        else
                        begin
                            mem_rd_q <= 1'b1;
                            state    <= ST_MEM_WAIT;
                        end
                    end
                end
                ST_MEM_WAIT:
                begin
                    if (mem_done)
                    begin
                        resp_valid_q <= 1'b1;
                        state        <= ST_FILL;
                    end
                end
                ST_FILL:
                begin
                    valid_q[fill_idx] <= 1'b1;
                    state             <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // the response data register also carries the fill line into the array
    always_ff @(posedge CLK)
    begin
        case (state)
            ST_IDLE:
            begin
                if (req)
                begin
                    addr_q      <= req_addr;
                    resp_data_q <= data_q[req_idx];
                    resp_src_q  <= SRC_L1;
                end
            end
            ST_VICTIM_WAIT:
            begin
                if (victim_done && victim_hit)
                begin
                    resp_data_q <= victim_data;
                    resp_src_q  <= SRC_VICTIM;
                end
            end
            ST_MEM_WAIT:
            begin
                if (mem_done)
                begin
                    resp_data_q <= mem_data;
                    resp_src_q  <= SRC_MEMORY;
                end
            end
            ST_FILL:
            begin
                tag_q[fill_idx]  <= fill_tag;
                data_q[fill_idx] <= resp_data_q;
            end
            default:
            begin
            end
        endcase
    end

    assign busy          = (state != ST_IDLE) || resp_valid_q;
    assign resp          = fetch_resp_t'{valid: resp_valid_q, data: resp_data_q,
                                         source: resp_src_q};
    assign victim_lookup = lookup_q;
    assign lookup_addr   = addr_q;
    assign mem_rd        = mem_rd_q;
    assign mem_addr      = addr_q;

    // the displaced line leaves while the new one is written over it
    assign victim_write  = (state == ST_FILL) && valid_q[fill_idx];
    assign victim_wentry = victim_entry_t'{addr: {tag_q[fill_idx], fill_idx},
                                           data: data_q[fill_idx]};

    a_no_req_while_busy: assert property (@(posedge CLK) disable iff (!rst_n)
        busy |-> !req)
        else $error("request raised while busy");

    a_resp_single_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
        resp.valid |=> !resp.valid)
        else $error("response valid held for more than one cycle");

endmodule

// ==== source/fetch_cache_top.sv ====
`timescale 1ns/1ps

module fetch_cache_top #(
    parameter int                       VICTIM_DEPTH   = 4,
    parameter mem_pkg::victim_latency_e VICTIM_LATENCY = mem_pkg::LAT_HIGH,
    parameter int                       MEM_LATENCY    = 3
) (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   req,
    input  cache_pkg::line_addr_t  req_addr,
    output logic                   busy,
    output cache_pkg::fetch_resp_t resp
);
    import cache_pkg::*;
    import mem_pkg::*;

    logic          victim_lookup;
    line_addr_t    lookup_addr;
    logic          victim_done;
    logic          victim_hit;
    line_t         victim_data;
    logic          victim_write;
    victim_entry_t victim_wentry;
    logic          mem_rd;
    line_addr_t    mem_addr;
    logic          mem_done;
    line_t         mem_data;

    fetch_cache_ctrl i_ctrl (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .req           (req),
        .req_addr      (req_addr),
        .busy          (busy),
        .resp          (resp),
        .victim_lookup (victim_lookup),
        .lookup_addr   (lookup_addr),
        .victim_done   (victim_done),
        .victim_hit    (victim_hit),
        .victim_data   (victim_data),
        .victim_write  (victim_write),
        .victim_wentry (victim_wentry),
        .mem_rd        (mem_rd),
        .mem_addr      (mem_addr),
        .mem_done      (mem_done),
        .mem_data      (mem_data)
    );

    victim_buffer #(
        .VICTIM_DEPTH   (VICTIM_DEPTH),
        .VICTIM_LATENCY (VICTIM_LATENCY)
    ) i_victim (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .victim_lookup (victim_lookup),
        .lookup_addr   (lookup_addr),
        .victim_write  (victim_write),
        .victim_wentry (victim_wentry),
        .victim_done   (victim_done),
        .victim_hit    (victim_hit),
        .victim_data   (victim_data)
    );

    line_memory #(
        .MEM_LATENCY (MEM_LATENCY)
    ) i_mem (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .mem_rd   (mem_rd),
        .mem_addr (mem_addr),
        .mem_done (mem_done),
        .mem_data (mem_data)
    );

endmodule

// ==== tests/tb_fetch_cache.sv ====
`timescale 1ns/1ps

module tb_fetch_cache;
    import cache_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int CYCLES_PER_REQ = 30;
    localparam int MAX_RECORDS    = 64;

    localparam logic [7:0] CMD_FETCH = 8'h00;
    localparam logic [7:0] CMD_RESET = 8'h01;   // reset the DUT, then fetch
    localparam logic [7:0] CMD_END   = 8'h0f;

    logic        CLK;
    logic        rst_n;
    logic        req;
    line_addr_t  req_addr;
    logic        busy;
    fetch_resp_t resp;

    logic [7:0]  stim_mem [3*MAX_RECORDS];   // three words per record
    line_t       image [NUM_LINES];
    int          num_records;
    int          num_resets;
    logic        stim_loaded;

    fetch_cache_top i_dut (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .req      (req),
        .req_addr (req_addr),
        .busy     (busy),
        .resp     (resp)
    );

    always #5 CLK = ~CLK;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input string name, input line_t got, input line_t exp);
        if (got !== exp)
        begin
            stop_on_error($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_source(input string name, input source_e got, input source_e exp);
        if (got !== exp)
        begin
            stop_on_error($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            stop_on_error($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    // walks the loaded records up to the end marker and rejects malformed ones
    task automatic count_records();
        logic [7:0] cmd;
        logic       found_end;
        found_end   = 1'b0;
        num_records = 0;
        num_resets  = 0;
        while (!found_end && num_records < MAX_RECORDS)
        begin
            cmd = stim_mem[3*num_records];
            if (cmd == CMD_END)
            begin
                found_end = 1'b1;
            end
            else if (cmd != CMD_FETCH && cmd != CMD_RESET)
            begin
                stop_on_error($sformatf("stim record %0d has an unknown command", num_records));
            end
            else if (stim_mem[3*num_records+2] > 8'h02)
            begin
                stop_on_error($sformatf("stim record %0d has an unknown source", num_records));
            end
            else
            begin
                if (cmd == CMD_RESET)
                begin
                    num_resets++;
                end
                num_records++;
            end
        end
        if (!found_end)
        begin
            stop_on_error("stim file has no end marker");
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;   // lands while the last response and its fill are still in progress
        req   = 1'b0;
        repeat (RESET_CYCLES) @(negedge CLK);
        rst_n = 1'b1;
        check_flag("busy after reset", busy, 1'b0);   // state is still the reset state here
        check_flag("resp.valid after reset", resp.valid, 1'b0);
    endtask

    task automatic fetch_and_check(input int idx, input line_addr_t addr, input source_e exp_src);
        int cycles;
        cycles = 0;
        while (busy)
        begin
            @(negedge CLK);
        end
        req      = 1'b1;
        req_addr = addr;
        @(negedge CLK);
        req    = 1'b0;
        cycles = 1;
        while (!resp.valid)
        begin
            @(negedge CLK);
            cycles++;
        end
        check_source($sformatf("resp.source (record %0d, addr %h)", idx, addr),
                     resp.source, exp_src);
        check_data($sformatf("resp.data (record %0d, addr %h)", idx, addr),
                   resp.data, image[addr]);
        if (exp_src == SRC_L1 && cycles != 1)
        begin
            stop_on_error($sformatf("L1 hit for record %0d answered after %0d cycles instead of 1",
                                    idx, cycles));
        end
    endtask

    // budget covers every request at its worst case plus each reset
    initial
    begin
        wait (stim_loaded);
        repeat ((num_records * CYCLES_PER_REQ) + ((num_resets + 1) * RESET_CYCLES)) @(posedge CLK);
        $display("timeout: the DUT did not finish the requests in time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        CLK         = 1'b0;
        rst_n       = 1'b0;
        req         = 1'b0;
        req_addr    = '0;
        stim_loaded = 1'b0;
        $readmemh("tests/fetch_stim.txt", stim_mem);
        $readmemh("tests/line_image.hex", image);
        count_records();
        stim_loaded = 1'b1;
        apply_reset();
        for (int i = 0; i < num_records; i++)
        begin
            if (stim_mem[3*i] == CMD_RESET)
            begin
                apply_reset();
            end
            fetch_and_check(i, stim_mem[3*i+1][LINE_ADDR_W-1:0],
                            source_e'(stim_mem[3*i+2][1:0]));
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== project.f ====
source/cache_pkg.sv
source/mem_pkg.sv
source/victim_buffer.sv
source/line_memory.sv
source/fetch_cache_ctrl.sv
source/fetch_cache_top.sv
tests/tb_fetch_cache.sv

// ==== Makefile ====
BIN := obj_dir/Vtb_fetch_cache

.PHONY: all run clean

all: $(BIN)

$(BIN): project.f $(shell cat project.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_cache \
		-f project.f -o Vtb_fetch_cache

run: $(BIN) tests/fetch_stim.txt tests/line_image.hex
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== tests/fetch_stim.txt ====
// columns: command (0 fetch, 1 reset then fetch, f end of list), line address, expected source
// expected source: 0 L1, 1 victim buffer, 2 backing memory
// cold misses, then L1 hits
0 00 2
0 01 2
0 02 2
0 03 2
0 00 0
0 02 0
0 01 0
// set 4 conflict, lines swap through the victim buffer
0 04 2
0 0c 2
0 04 1
0 0c 1
0 04 1
0 04 0
// five evictions overflow the buffer
0 08 2
0 10 2
0 18 2
0 09 2
0 11 2
0 00 2
0 10 1
0 09 1
0 01 1
0 08 2
// lines leave the buffer when they are returned
0 00 1
0 08 1
0 00 1
0 0a 2
0 09 1
0 10 1
0 11 2
0 00 1
0 08 2
0 02 2
// reset clears L1 and the victim buffer
1 02 2
0 00 2
0 02 0
0 08 2
0 00 1
f 00 0

// ==== tests/line_image.hex ====
// one 64-bit line per line address, address 00 first
00c3ff5a0096ff0f
01c3fe5a0196fe0f
02c3fd5a0296fd0f
03c3fc5a0396fc0f
04c3fb5a0496fb0f
05c3fa5a0596fa0f
06c3f95a0696f90f
07c3f85a0796f80f
08c3f75a0896f70f
09c3f65a0996f60f
0ac3f55a0a96f50f
0bc3f45a0b96f40f
0cc3f35a0c96f30f
0dc3f25a0d96f20f
0ec3f15a0e96f10f
0fc3f05a0f96f00f
10c3ef5a1096ef0f
11c3ee5a1196ee0f
12c3ed5a1296ed0f
13c3ec5a1396ec0f
14c3eb5a1496eb0f
15c3ea5a1596ea0f
16c3e95a1696e90f
17c3e85a1796e80f
18c3e75a1896e70f
19c3e65a1996e60f
1ac3e55a1a96e50f
1bc3e45a1b96e40f
1cc3e35a1c96e30f
1dc3e25a1d96e20f
1ec3e15a1e96e10f
1fc3e05a1f96e00f
